// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_wed_afu -f capi_wed.f -o tb_wed_afu
	./obj_dir/tb_wed_afu | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== capi_wed.f ====
+incdir+common
common/capi_wed_pkg.sv
verilog/tagged_buffer.sv
wed/wed_control.sv
verilog/wed_afu_top.sv
tb/tb_wed_afu.sv

// ==== common/capi_wed_config.svh ====
// Widths, ids and buffer sizing shared by RTL and testbench
// Buffer depths must be 2 or more, margin below depth
`ifndef CAPI_WED_CONFIG_SVH
`define CAPI_WED_CONFIG_SVH

// --------------------
// Host line geometry
`define CACHELINE_BITS      1024
`define CACHELINE_HALF_BITS 512  // One data beat
`define ADDR_BITS           64

// --------------------
// Compute-unit ids
`define WED_ID 8'h01  // Owner of the descriptor fetch

// --------------------
// Buffers
`define CMD_BUF_DEPTH     4
`define RSP_BUF_DEPTH     8
`define BUF_ALFULL_MARGIN 2  // Free slots left when alfull rises

`endif

// ==== common/capi_wed_pkg.sv ====
// Types for the descriptor fetch path
// Descriptor fields sit in 64-bit slots from bit 0 of the line
`default_nettype none
`include "capi_wed_config.svh"

package capi_wed_pkg;

  // --------------------
  // Host opcodes and responses
  typedef enum logic [12:0] {
    READ_CL_NA = 13'h0A00,  // Full line read, no allocate
    READ_CL_S  = 13'h0A50,
    WRITE_NA   = 13'h0D00
  } command_e;

  typedef enum logic [7:0] {
    DONE    = 8'h00,
    AERROR  = 8'h01,
    DERROR  = 8'h03,
    FLUSHED = 8'h06,
    FAULT   = 8'h0A,
    FAILED  = 8'h0B,
    PAGED   = 8'h0E
  } response_e;

  typedef enum logic [7:0] {
    CMD_INVALID = 8'h00,
    CMD_WED     = 8'h01,
    CMD_READ    = 8'h02,
    CMD_WRITE   = 8'h03
  } cmd_type_e;

  // --------------------
  // Bus lines, each with its own valid
  typedef struct packed {
    logic [7:0] cu_id;     // Routing key
    cmd_type_e  cmd_type;
    logic [7:0] tag;
  } cmd_tag_t;

  typedef struct packed {
    logic                  valid;
    command_e              command;
    logic [`ADDR_BITS-1:0] address;
    logic [11:0]           size;     // Bytes
    cmd_tag_t              cmd;
  } command_line_t;

  typedef struct packed {
    logic                            valid;
    cmd_tag_t                        cmd;
    logic [`CACHELINE_HALF_BITS-1:0] data;
  } read_data_t;

  typedef struct packed {
    logic      valid;
    cmd_tag_t  cmd;
    response_e response;
  } response_line_t;

  typedef struct packed {
    logic empty;
    logic alfull;
    logic full;
  } buffer_status_t;

  // --------------------
  // Work element descriptor
  localparam int WED_SLOT_BITS = 64;
  localparam int WED_USED_BITS = 5 * WED_SLOT_BITS;  // Five decoded slots

  typedef struct packed {
    logic [31:0]                              size_send;
    logic [31:0]                              size_recv;
    logic [`ADDR_BITS-1:0]                    array_send;
    logic [`ADDR_BITS-1:0]                    array_recv;
    logic [31:0]                              flags;
    logic [`CACHELINE_BITS-WED_USED_BITS-1:0] reserved;  // Rest of line
  } wed_t;

  typedef struct packed {
    logic                  valid;
    logic [`ADDR_BITS-1:0] address;  // Where the WED was read from
    wed_t                  wed;
  } wed_request_t;

  typedef enum logic [2:0] {WED_RESET, WED_IDLE, WED_REQ, WED_WAIT_RESP, WED_DONE} wed_state_e;

  // Slot n starts at bit 64*n, 32-bit fields use the low half
  function automatic wed_t map_line_to_wed(input logic [`CACHELINE_BITS-1:0] line);
    wed_t wed;
    wed.size_send  = line[0*WED_SLOT_BITS +: 32];
    wed.size_recv  = line[1*WED_SLOT_BITS +: 32];
    wed.array_send = line[2*WED_SLOT_BITS +: `ADDR_BITS];
    wed.array_recv = line[3*WED_SLOT_BITS +: `ADDR_BITS];
    wed.flags      = line[4*WED_SLOT_BITS +: 32];
    wed.reserved   = line[`CACHELINE_BITS-1:WED_USED_BITS];
    return wed;
  endfunction

endpackage

`default_nettype wire

// ==== tb/tb_wed_afu.sv ====
// Twenty fetch trials, each behind its own reset; host model answers the one read
// Foreign ids, non-DONE codes and command_ready stalls come from the LCG
`timescale 1ns/1ps
`default_nettype none
`include "capi_wed_config.svh"

module tb_wed_afu import capi_wed_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int TRIALS       = 20;
  localparam int MAX_IDLE     = 8;   // Cycles with enable low
  localparam int MAX_STALL    = 12;  // Ready low once the command shows
  localparam int MAX_DELAY    = 10;  // Host latency before the beats
  localparam int WAIT_LIMIT   = 64;
  localparam int TRIAL_CYCLES = 2 + MAX_IDLE + MAX_DELAY + 2 * WAIT_LIMIT + 10;

  logic                  clock, rstn, enabled_in, command_ready;
  logic [`ADDR_BITS-1:0] wed_address;
  read_data_t            data_0_in, data_1_in;
  response_line_t        response_in;
  command_line_t         command_out;
  buffer_status_t        response_status;
  wed_request_t          wed_request;

  logic [31:0]           lcg_state = 32'hecf0_d86b;
  logic [`ADDR_BITS-1:0] exp_address;   // Address of the running trial
  cmd_tag_t              last_tag;      // Tag of the last accepted command
  int                    cmd_count = 0; // Accepted commands, whole run
  int                    rsp_count = 0; // Model occupancy of the response buffer
  int                    errors    = 0;

  wed_afu_top dut_i (
    .clock           (clock),
    .rstn            (rstn),
    .enabled_in      (enabled_in),
    .wed_address     (wed_address),
    .command_ready   (command_ready),
    .data_0_in       (data_0_in),
    .data_1_in       (data_1_in),
    .response_in     (response_in),
    .command_out     (command_out),
    .response_status (response_status),
    .wed_request     (wed_request)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Twice the worst trial, all waits at their limit
  initial begin
    #(2 * TRIALS * TRIAL_CYCLES * CLK_PERIOD);
    $display("Watchdog expired at %0t, the run did not finish", $time);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------
  // Random source and helpers
  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ {16'h0000, lcg_state[31:16]};  // Fold high bits down
  endfunction

  function automatic logic [`CACHELINE_HALF_BITS-1:0] random_half();
    logic [`CACHELINE_HALF_BITS-1:0] half;
    for (int i = 0; i < `CACHELINE_HALF_BITS / 32; i++) half[i*32 +: 32] = rand32();
    return half;
  endfunction

  function automatic logic [7:0] foreign_id();
    logic [31:0] r;
    r = rand32();
    return (r[7:0] == `WED_ID) ? ~r[7:0] : r[7:0];  // Anything but the owner
  endfunction

  task automatic check_value(input string name, input logic [1023:0] got,
                             input logic [1023:0] expected);
    if (got !== expected) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  // One edge, outputs seen as they were just before it
  task automatic tick();
    buffer_status_t exp_status;
    logic           pop_ok;
    @(posedge clock);
    if (!rstn) rsp_count = 0;  // Buffer held empty in reset
    exp_status.empty  = (rsp_count == 0);
    exp_status.alfull = (rsp_count >= `RSP_BUF_DEPTH - `BUF_ALFULL_MARGIN);
    exp_status.full   = (rsp_count == `RSP_BUF_DEPTH);
    check_value("response_status", 1024'(response_status), 1024'(exp_status));
    if (rstn) begin  // Drained one entry per cycle, push only with room
      pop_ok = (rsp_count > 0);
      if (response_in.valid && rsp_count < `RSP_BUF_DEPTH) rsp_count++;
      if (pop_ok) rsp_count--;
    end
    if (rstn && command_out.valid && command_ready) begin  // Host takes the command
      cmd_count++;
      last_tag = command_out.cmd;
      check_value("command_out.command", 1024'(command_out.command), 1024'(READ_CL_NA));
      check_value("command_out.address", 1024'(command_out.address), 1024'(exp_address));
      check_value("command_out.size", 1024'(command_out.size), 1024'(128));
      check_value("command_out.cmd.cu_id", 1024'(command_out.cmd.cu_id), 1024'(`WED_ID));
    end
    if (!enabled_in) begin  // Quiet outputs until enable
      check_value("command_out.valid", 1024'(command_out.valid), 1024'(0));
      check_value("wed_request.valid", 1024'(wed_request.valid), 1024'(0));
    end
  endtask

  // Foreign beats, foreign or non-DONE responses, random ready
  task automatic drive_noise();
    logic [31:0]    r;
    read_data_t     beat;
    response_line_t rsp;
    r              = rand32();
    beat           = '0;
    rsp            = '0;
    beat.cmd.cu_id = foreign_id();
    beat.cmd.tag   = r[15:8];
    beat.data      = random_half();
    beat.valid     = r[0];
    data_0_in     <= beat;
    beat.valid     = r[1];
    data_1_in     <= beat;
    rsp.valid      = r[2] && !response_status.alfull;
    rsp.cmd.tag    = r[23:16];
    rsp.cmd.cu_id  = r[3] ? foreign_id() : `WED_ID;
    rsp.response   = r[3] ? DONE : (r[4] ? AERROR : PAGED);  // Owner never sees DONE here
    response_in   <= rsp;
    command_ready <= r[5];
  endtask

  // --------------------
  // One trial
  task automatic run_trial();
    logic [`CACHELINE_BITS-1:0] line;
    read_data_t                 beat_0, beat_1;
    response_line_t             done_rsp;
    wed_t                       got_wed;
    logic [31:0]                mode;
    int                         stall, waited, start_count;
    line           = {random_half(), random_half()};
    exp_address    = {rand32(), rand32()} & ~64'h7F;  // Line aligned
    rstn          <= 1'b0;
    enabled_in    <= 1'b0;
    command_ready <= 1'b0;
    wed_address   <= exp_address;
    data_0_in     <= '0;
    data_1_in     <= '0;
    response_in   <= '0;
    repeat (2) tick();
    rstn        <= 1'b1;
    start_count  = cmd_count;
    repeat (1 + rand32() % MAX_IDLE) tick();  // Enable low, outputs must stay quiet
    enabled_in    <= 1'b1;
    stall          = rand32() % (MAX_STALL + 1);
    command_ready <= (stall == 0);
    waited         = 0;
    while (cmd_count == start_count && waited < WAIT_LIMIT) begin
      tick();
      waited++;
      if (command_out.valid && stall > 0) stall--;  // Stall counts from first sight
      command_ready <= (stall == 0);
    end
    if (cmd_count == start_count) begin
      errors++;
      $display("Trial timed out waiting for the read command");
      return;
    end
    repeat (rand32() % (MAX_DELAY + 1)) begin
      drive_noise();
      tick();
    end
    // Line comes back under the command's tag
    beat_0   = {1'b1, last_tag, line[`CACHELINE_HALF_BITS-1:0]};
    beat_1   = {1'b1, last_tag, line[`CACHELINE_BITS-1:`CACHELINE_HALF_BITS]};
    done_rsp = {1'b1, last_tag, DONE};
    mode     = rand32();
    data_0_in   <= mode[0] ? beat_0 : '0;  // Beats split over two cycles by mode
    data_1_in   <= mode[1] ? beat_1 : '0;
    response_in <= '0;
    tick();
    data_0_in   <= mode[0] ? '0 : beat_0;
    data_1_in   <= mode[1] ? '0 : beat_1;
    response_in <= done_rsp;  // DONE with or after the last beat
    tick();
    waited = 0;
    while (!wed_request.valid && waited < WAIT_LIMIT) begin
      drive_noise();
      tick();
      waited++;
    end
    if (!wed_request.valid) begin
      errors++;
      $display("Trial timed out waiting for wed_request.valid");
      return;
    end
    // Model decode, slot n at bit 64*n, 32-bit fields in the low half
    got_wed = wed_request.wed;
    check_value("wed_request.address", 1024'(wed_request.address), 1024'(exp_address));
    check_value("wed_request.wed.size_send", 1024'(got_wed.size_send), 1024'(line[31:0]));
    check_value("wed_request.wed.size_recv", 1024'(got_wed.size_recv), 1024'(line[95:64]));
    check_value("wed_request.wed.array_send", 1024'(got_wed.array_send), 1024'(line[191:128]));
    check_value("wed_request.wed.array_recv", 1024'(got_wed.array_recv), 1024'(line[255:192]));
    check_value("wed_request.wed.flags", 1024'(got_wed.flags), 1024'(line[287:256]));
    check_value("wed_request.wed.reserved", 1024'(got_wed.reserved), 1024'(line[1023:320]));
    repeat (8) begin  // Ready keeps toggling, no second command allowed
      drive_noise();
      tick();
    end
    check_value("wed_request.valid", 1024'(wed_request.valid), 1024'(1));
    check_value("command count", 1024'(cmd_count - start_count), 1024'(1));
  endtask

  initial begin
    for (int t = 0; t < TRIALS; t++) run_trial();
    $display("Trials: %0d, commands: %0d, errors: %0d", TRIALS, cmd_count, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/tagged_buffer.sv ====
// Circular FIFO, payload_t needs a valid field; DEPTH of 2 or more
// Caller must not push when full or pop when empty
`timescale 1ns/1ps
`default_nettype none

module tagged_buffer import capi_wed_pkg::*; #(
  parameter type payload_t     = command_line_t,
  parameter int  DEPTH         = 4,
  parameter int  ALFULL_MARGIN = 1
) (
  input  logic           clock,
  input  logic           rstn,
  input  logic           push,
  input  payload_t       push_data,
  input  logic           pop,
  output payload_t       pop_data,   // Head entry, valid low when empty
  output buffer_status_t status
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr, rd_next;
  logic [CNT_W-1:0] count, count_next;
  logic             do_push, do_pop;
  payload_t         head_next;

  assign do_push = push && !status.full;
  assign do_pop  = pop && !status.empty;

  // --------------------
  // Next head and occupancy
  assign rd_next    = !do_pop ? rd_ptr : (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
  assign count_next = count + CNT_W'(do_push) - CNT_W'(do_pop);
  // Pushed entry becomes head at once when nothing else is queued
  assign head_next  = (do_push && (count - CNT_W'(do_pop)) == '0) ? push_data : mem[rd_next];

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      pop_data <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      rd_ptr         <= rd_next;
      count          <= count_next;
      pop_data       <= head_next;
      pop_data.valid <= (count_next != '0);  // Tracks !empty
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  // --------------------
  // Status from occupancy
  assign status.empty  = (count == '0);
  assign status.full   = (count == CNT_W'(DEPTH));
  assign status.alfull = (count >= CNT_W'(DEPTH - ALFULL_MARGIN));

  a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
    push |-> !status.full);
  a_no_underflow: assert property (@(posedge clock) disable iff (!rstn)
    pop |-> !status.empty);

endmodule

`default_nettype wire

// ==== verilog/wed_afu_top.sv ====
// Host must respect response_status.alfull before sending responses
// Data beats go straight to the controller, unbuffered
`timescale 1ns/1ps
`default_nettype none
`include "capi_wed_config.svh"

module wed_afu_top import capi_wed_pkg::*; (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic                  enabled_in,
  input  logic [`ADDR_BITS-1:0] wed_address,
  input  logic                  command_ready,  // Host takes command_out
  input  read_data_t            data_0_in,
  input  read_data_t            data_1_in,
  input  response_line_t        response_in,
  output command_line_t         command_out,
  output buffer_status_t        response_status,
  output wed_request_t          wed_request
);

  command_line_t  wed_cmd;     // Controller to command buffer
  buffer_status_t cmd_status;
  response_line_t rsp_line;    // Response buffer to controller

  // --------------------
  // Command path
  tagged_buffer #(
    .payload_t     (command_line_t),
    .DEPTH         (`CMD_BUF_DEPTH),
    .ALFULL_MARGIN (`BUF_ALFULL_MARGIN)
  ) cmd_buf_i (
    .clock     (clock),
    .rstn      (rstn),
    .push      (wed_cmd.valid),
    .push_data (wed_cmd),
    .pop       (command_ready && !cmd_status.empty),  // Held under back-pressure
    .pop_data  (command_out),
    .status    (cmd_status)
  );

  // --------------------
  // Response path, drained every cycle
  tagged_buffer #(
    .payload_t     (response_line_t),
    .DEPTH         (`RSP_BUF_DEPTH),
    .ALFULL_MARGIN (`BUF_ALFULL_MARGIN)
  ) rsp_buf_i (
    .clock     (clock),
    .rstn      (rstn),
    .push      (response_in.valid),
    .push_data (response_in),
    .pop       (!response_status.empty),
    .pop_data  (rsp_line),
    .status    (response_status)
  );

  wed_control wed_control_i (
    .clock                 (clock),
    .rstn                  (rstn),
    .enabled_in            (enabled_in),
    .wed_address           (wed_address),
    .data_0_in             (data_0_in),
    .data_1_in             (data_1_in),
    .response_in           (rsp_line),
    .command_buffer_status (cmd_status),
    .command_out           (wed_cmd),
    .wed_request_out       (wed_request)
  );

endmodule

`default_nettype wire

// ==== wed/wed_control.sv ====
// One descriptor fetch per reset, later enables are ignored
// Both data beats must arrive no later than the DONE response
`timescale 1ns/1ps
`default_nettype none
`include "capi_wed_config.svh"

module wed_control import capi_wed_pkg::*; (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic                  enabled_in,
  input  logic [`ADDR_BITS-1:0] wed_address,
  input  read_data_t            data_0_in,              // Low half of line
  input  read_data_t            data_1_in,              // High half of line
  input  response_line_t        response_in,
  input  buffer_status_t        command_buffer_status,
  output command_line_t         command_out,
  output wed_request_t          wed_request_out
);

  wed_state_e                  current_state, next_state;
  logic                        enabled;
  logic [`CACHELINE_BITS-1:0]  wed_line;                 // Gathered halves
  logic                        data_0_hit, data_1_hit;
  logic                        done_hit;

  // --------------------
  // Input qualification
  assign data_0_hit = data_0_in.valid && (data_0_in.cmd.cu_id == `WED_ID);
  assign data_1_hit = data_1_in.valid && (data_1_in.cmd.cu_id == `WED_ID);
  assign done_hit   = response_in.valid && (response_in.cmd.cu_id == `WED_ID) &&
                      (response_in.response == DONE);  // Other codes ignored

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;  // One cycle of delay on enable
    end
  end

  // --------------------
  // FSM
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      current_state <= WED_RESET;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      WED_RESET:     next_state = WED_IDLE;
      WED_IDLE: begin
        // No refetch once a descriptor is out
        if (enabled && !wed_request_out.valid && !command_buffer_status.alfull)
          next_state = WED_REQ;
      end
      WED_REQ:       next_state = WED_WAIT_RESP;
      WED_WAIT_RESP: if (done_hit) next_state = WED_DONE;  // Latency set by host
      WED_DONE:      next_state = WED_IDLE;
      default:       next_state = WED_RESET;
    endcase
  end

  // --------------------
  // Command and descriptor outputs
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_out     <= '0;
      wed_request_out <= '0;
    end else begin
      command_out.valid <= 1'b0;  // Single-cycle push into command buffer
      case (current_state)
        WED_REQ: begin
          command_out.valid        <= 1'b1;
          command_out.command      <= READ_CL_NA;
          command_out.address      <= wed_address;
          command_out.size         <= 12'd128;  // Whole line
          command_out.cmd.cu_id    <= `WED_ID;
          command_out.cmd.cmd_type <= CMD_WED;
          command_out.cmd.tag      <= 8'h00;
          wed_request_out.address  <= wed_address;
        end
        WED_DONE: begin
          wed_request_out.valid <= 1'b1;  // Held until reset
          wed_request_out.wed   <= map_line_to_wed(wed_line);
        end
        default: ;
      endcase
    end
  end

  // Gather beats while waiting, foreign ids pass by
  always_ff @(posedge clock) begin
    if (current_state == WED_WAIT_RESP) begin
      if (data_0_hit) wed_line[`CACHELINE_HALF_BITS-1:0] <= data_0_in.data;
      if (data_1_hit) wed_line[`CACHELINE_BITS-1:`CACHELINE_HALF_BITS] <= data_1_in.data;
    end
  end

  // --------------------
  // Checks
  a_cmd_pulse: assert property (@(posedge clock) disable iff (!rstn)
    command_out.valid |=> !command_out.valid);

  // Room was seen in IDLE, two cycles before the push
  a_cmd_room: assert property (@(posedge clock) disable iff (!rstn)
    command_out.valid |-> $past(!command_buffer_status.alfull, 2));

endmodule

`default_nettype wire
